// ==== sources.f ====
hdl/chuchu_pkg.sv
hdl/sample_ring.sv
hdl/shadow_page_store.sv
hdl/snapshot_sequencer.sv
hdl/chuchu_top.sv
tb/chuchu_assertions.sv
tb/chuchu_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds the testbench with Verilator, runs it and looks for the pass line

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=chuchu_sim

verilator --binary --timing --assert \
    --timescale 1ns/100ps \
    --top-module chuchu_tb \
    --Mdir "$BUILD_DIR" \
    -o "$SIM_BIN" \
    -f sources.f
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "build failed with status $build_status"
    exit 1
fi

sim_output=$("./$BUILD_DIR/$SIM_BIN" 2>&1)
sim_status=$?
printf '%s\n' "$sim_output"

if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if printf '%s\n' "$sim_output" | grep -qx "sim passed"; then
    echo "result: pass"
    exit 0
else
    echo "result: fail"
    exit 1
fi

// ==== tb/chuchu_tb.sv ====
module chuchu_tb
    import chuchu_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int        SEED         = 57546;
    localparam int        RESET_CYCLES = 8;
    // about 2650 cycles of tests plus margin
    localparam int        MAX_CYCLES   = 4000;
    localparam snap_cmd_t NO_CMD       = '0;

    localparam page_t SAVE_ORDER    [4] = '{3'd0, 3'd1, 3'd3, 3'd7};
    localparam page_t RESTORE_ORDER [4] = '{3'd3, 3'd0, 3'd7, 3'd1};

    typedef struct packed {
        sample_t out;
        logic    busy;
    } expect_t;

    logic      clk = 1'b0;
    logic      reset;
    sample_t   rat_data;
    snap_cmd_t cmd;
    sample_t   chuchu_out;
    logic      busy;

    int cycle_count = 0;

    // model state
    sample_t model_ring  [DEPTH];
    sample_t model_pages [PAGES][DEPTH];
    index_t  model_index;
    int      model_busy; // busy edges still to come

    always #2 clk = ~clk;

    chuchu_top UUT (
        .clk        (clk),
        .reset      (reset),
        .rat_data   (rat_data),
        .cmd        (cmd),
        .chuchu_out (chuchu_out),
        .busy       (busy)
    );

    function automatic void model_reset();
        for (int i = 0; i < DEPTH; i++) begin
            model_ring[i] = sample_t'(RESET_BASE + i);
        end
        for (int p = 0; p < PAGES; p++) begin
            for (int i = 0; i < DEPTH; i++) begin
                model_pages[p][i] = '0;
            end
        end
        model_index = '0;
        model_busy  = 0;
    endfunction

    // one clock edge of the line with commands as an instant copy
    function automatic expect_t model_edge(input sample_t data, input snap_cmd_t c);
        expect_t res;
        res.out = model_ring[model_index];
        model_ring[model_index] = data;
        if (model_busy == 0 && (c.save || c.restore)) begin
            if (c.save) begin // save beats restore
                for (int i = 0; i < DEPTH; i++) begin
                    model_pages[c.page][i] = model_ring[i];
                end
            end else begin
                for (int i = 0; i < DEPTH; i++) begin
                    model_ring[i] = model_pages[c.page][i];
                end
            end
            model_busy = DEPTH;
        end else if (model_busy > 0) begin
            model_busy--;
        end
        model_index = index_t'((int'(model_index) + 1) % DEPTH);
        res.busy = (model_busy > 0);
        return res;
    endfunction

    always begin : compare_outputs
        expect_t exp_now;
        @(posedge clk);
        if (reset) begin
            model_reset();
            exp_now = '0;
        end else begin
            exp_now = model_edge(rat_data, cmd);
        end
        @(negedge clk); // outputs settled
        assert (chuchu_out === exp_now.out && busy === exp_now.busy) else begin
            $display("error: at %0.1f ns out %0d busy %0b, expected out %0d busy %0b",
                     $realtime, chuchu_out, busy, exp_now.out, exp_now.busy);
            $display("sim failed");
            $fatal(1, "DUT output differs from the reference model");
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("sim failed");
            $fatal(1, "timeout: run did not finish within %0d cycles", MAX_CYCLES);
        end
    end

    function automatic sample_t rand_sample();
        return sample_t'($urandom);
    endfunction

    function automatic snap_cmd_t make_cmd(input logic save, input logic restore, input page_t pg);
        snap_cmd_t c;
        c.save    = save;
        c.restore = restore;
        c.page    = pg;
        return c;
    endfunction

    function automatic snap_cmd_t random_cmd();
        snap_cmd_t c;
        c.save    = ($urandom_range(1) == 1);
        c.restore = ($urandom_range(1) == 1);
        c.page    = page_t'($urandom_range(PAGES - 1));
        return c;
    endfunction

    // called 1 ns after an edge and returns 1 ns after the next one
    task automatic step(input sample_t d, input snap_cmd_t c);
        rat_data = d;
        cmd      = c;
        @(posedge clk);
        #1;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) step(rand_sample(), NO_CMD);
    endtask

    task automatic wait_idle();
        while (busy) begin
            step(rand_sample(), NO_CMD);
        end
    endtask

    task automatic expect_output(input sample_t want, input string what);
        assert (chuchu_out === want) else begin
            $display("error: at %0.1f ns %s, chuchu_out %0d, expected %0d",
                     $realtime, what, chuchu_out, want);
            $display("sim failed");
            $fatal(1, "unexpected output value");
        end
    endtask

    initial begin : stimulus
        sample_t sent [$];
        sample_t d;
        int      busy_len;

        void'($urandom(SEED));
        reset    = 1'b1;
        rat_data = '0;
        cmd      = NO_CMD;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset = 1'b0;

        // reset ramp, then plain delay
        for (int i = 0; i < DEPTH; i++) begin
            d = rand_sample();
            sent.push_back(d);
            step(d, NO_CMD);
            expect_output(sample_t'(RESET_BASE + i), "reset contents");
        end
        for (int i = 0; i < DEPTH; i++) begin
            d = rand_sample();
            sent.push_back(d);
            step(d, NO_CMD);
            expect_output(sent.pop_front(), "128-cycle delay");
        end

        // save, new data, restore
        step(rand_sample(), make_cmd(1'b1, 1'b0, 3'd2));
        wait_idle();
        idle_cycles(50);
        step(rand_sample(), make_cmd(1'b0, 1'b1, 3'd2));
        wait_idle();
        idle_cycles(4);

        // page 5 is never saved
        step(rand_sample(), make_cmd(1'b0, 1'b1, 3'd5));
        for (int i = 0; i < DEPTH; i++) begin
            step(rand_sample(), NO_CMD);
            expect_output('0, "restore of an empty page");
        end
        idle_cycles(4);

        // strobes during a save are dropped
        step(rand_sample(), make_cmd(1'b1, 1'b0, 3'd1));
        busy_len = 0;
        do begin
            step(rand_sample(), random_cmd());
            busy_len++;
        end while (busy && busy_len < 2 * DEPTH);
        assert (busy_len == DEPTH) else begin
            $display("error: at %0.1f ns busy lasted %0d cycles, expected %0d",
                     $realtime, busy_len, DEPTH);
            $display("sim failed");
            $fatal(1, "busy span has the wrong length");
        end
        idle_cycles(10);
        step(rand_sample(), make_cmd(1'b0, 1'b1, 3'd1));
        wait_idle();
        step(rand_sample(), make_cmd(1'b0, 1'b1, 3'd4)); // still empty
        wait_idle();
        idle_cycles(4);

        // both strobes at once
        step(rand_sample(), make_cmd(1'b1, 1'b1, 3'd6));
        wait_idle();
        idle_cycles(20);
        step(rand_sample(), make_cmd(1'b0, 1'b1, 3'd6));
        wait_idle();

        // several pages, restored out of order
        foreach (SAVE_ORDER[k]) begin
            step(rand_sample(), make_cmd(1'b1, 1'b0, SAVE_ORDER[k]));
            wait_idle();
            idle_cycles(20);
        end
        foreach (RESTORE_ORDER[k]) begin
            step(rand_sample(), make_cmd(1'b0, 1'b1, RESTORE_ORDER[k]));
            wait_idle();
            idle_cycles(4);
        end

        idle_cycles(DEPTH);
        $display("sim passed");
        $finish;
    end

endmodule

// ==== tb/chuchu_assertions.sv ====
module chuchu_tb_assertions
    import chuchu_pkg::*;
(
    input logic  clk,
    input logic  reset,
    input logic  busy,
    input logic  save_we,
    input logic  replay_en,
    input page_t page
);

    timeunit 1ns;
    timeprecision 100ps;

    int busy_run; // edges seen with busy high

    always_ff @(posedge clk) begin
        if (reset) begin
            busy_run <= 0;
        end else if (busy) begin
            busy_run <= busy_run + 1;
        end else begin
            busy_run <= 0;
        end
    end

    enables_exclusive: assert property (@(posedge clk) disable iff (reset)
        !(save_we && replay_en))
        else $error("save and replay enables high together");

    busy_span: assert property (@(posedge clk) disable iff (reset)
        $fell(busy) |-> busy_run == DEPTH)
        else $error("busy fell after %0d cycles", busy_run);

    busy_bound: assert property (@(posedge clk) disable iff (reset)
        busy |-> busy_run < DEPTH)
        else $error("busy held longer than a full pass");

    page_stable: assert property (@(posedge clk) disable iff (reset)
        busy && $past(busy) |-> $stable(page))
        else $error("page changed during a sequence");

endmodule

bind snapshot_sequencer chuchu_tb_assertions u_seq_checks (
    .clk       (clk),
    .reset     (reset),
    .busy      (busy),
    .save_we   (save_we),
    .replay_en (replay_en),
    .page      (page)
);

// ==== hdl/chuchu_top.sv ====
module chuchu_top
    import chuchu_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  sample_t   rat_data,
    input  snap_cmd_t cmd,
    output sample_t   chuchu_out,
    output logic      busy
);

    index_t     cur_index;
    sample_t    outgoing;
    sample_t    page_rdata;
    logic       replay_en;
    logic       save_we;
    page_t      active_page;
    page_addr_t rd_addr;
    page_addr_t wr_addr;

    // both ports follow the ring index
    assign rd_addr = '{page: active_page, index: cur_index};
    assign wr_addr = '{page: active_page, index: cur_index};

    sample_ring u_ring (
        .clk        (clk),
        .reset      (reset),
        .rat_data   (rat_data),
        .replay_en  (replay_en),
        .page_rdata (page_rdata),
        .cur_index  (cur_index),
        .outgoing   (outgoing),
        .chuchu_out (chuchu_out)
    );

    shadow_page_store u_store (
        .clk   (clk),
        .reset (reset),
        .raddr (rd_addr),
        .rdata (page_rdata),
        .we    (save_we),
        .waddr (wr_addr),
        .wdata (outgoing) // snapshot of the leaving value
    );

    snapshot_sequencer u_seq (
        .clk       (clk),
        .reset     (reset),
        .cmd       (cmd),
        .busy      (busy),
        .save_we   (save_we),
        .replay_en (replay_en),
        .page      (active_page)
    );

endmodule

// ==== hdl/snapshot_sequencer.sv ====
module snapshot_sequencer
    import chuchu_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  snap_cmd_t cmd,
    output logic      busy,
    output logic      save_we,
    output logic      replay_en,
    output page_t     page
);

    typedef enum logic [1:0] {
        SEQ_IDLE,
        SEQ_SAVE,
        SEQ_RESTORE
    } seq_state_t;

    seq_state_t state;
    seq_state_t state_next;
    index_t     count;
    logic       last_cycle;
    logic       accept;

    // strobes only count while idle
    assign accept     = (state == SEQ_IDLE) && (cmd.save || cmd.restore);
    assign last_cycle = (count == index_t'(DEPTH - 1));

    always_comb begin
        state_next = state;
        case (state)
            SEQ_IDLE: begin
                if (cmd.save) begin
                    state_next = SEQ_SAVE; // save beats restore
                end else if (cmd.restore) begin
                    state_next = SEQ_RESTORE;
                end
            end
            SEQ_SAVE,
            SEQ_RESTORE: begin
                if (last_cycle) begin
                    state_next = SEQ_IDLE;
                end
            end
            default: begin
                state_next = SEQ_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= SEQ_IDLE;
            count <= '0;
        end else begin
            state <= state_next;
            if (accept) begin
                count <= '0;
            end else if (state != SEQ_IDLE) begin
                count <= count + 1'b1; // one entry per cycle
            end
        end
    end

    // page held for the whole sequence
    always_ff @(posedge clk) begin
        if (reset) begin
            page <= '0;
        end else if (accept) begin
            page <= cmd.page;
        end
    end

    assign busy      = (state != SEQ_IDLE);
    assign save_we   = (state == SEQ_SAVE);
    assign replay_en = (state == SEQ_RESTORE);

endmodule

// ==== hdl/shadow_page_store.sv ====
module shadow_page_store
    import chuchu_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  page_addr_t raddr,
    output sample_t    rdata,
    input  logic       we,
    input  page_addr_t waddr,
    input  sample_t    wdata
);

    // PAGES x DEPTH snapshot entries
    sample_t page_mem [PAGES][DEPTH];

    assign rdata = page_mem[raddr.page][raddr.index]; // async read

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int p = 0; p < PAGES; p++) begin
                for (int i = 0; i < DEPTH; i++) begin
                    page_mem[p][i] <= '0;
                end
            end
        end else if (we) begin
            page_mem[waddr.page][waddr.index] <= wdata;
        end
    end

endmodule

// ==== hdl/sample_ring.sv ====
module sample_ring
    import chuchu_pkg::*;
(
    input  logic    clk,
    input  logic    reset,
    input  sample_t rat_data,
    input  logic    replay_en,
    input  sample_t page_rdata,
    output index_t  cur_index,
    output sample_t outgoing,
    output sample_t chuchu_out
);

    sample_t ring_mem [DEPTH];
    index_t  next_index;

    // value leaving the ring at the next edge
    always_comb begin
        if (replay_en) begin
            outgoing = page_rdata; // page value replaces the stored one
        end else begin
            outgoing = ring_mem[cur_index];
        end
    end

    assign next_index = cur_index + 1'b1; // wraps at DEPTH

    // storage reloads a ramp on reset
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < DEPTH; i++) begin
                ring_mem[i] <= sample_t'(RESET_BASE + i);
            end
        end else begin
            ring_mem[cur_index] <= rat_data; // slot just emptied
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            cur_index  <= '0;
            chuchu_out <= '0;
        end else begin
            cur_index  <= next_index;
            chuchu_out <= outgoing;
        end
    end

endmodule

// ==== hdl/chuchu_pkg.sv ====
package chuchu_pkg;

    // ring geometry
    localparam int DEPTH      = 128;
    localparam int PAGES      = 8;
    localparam int RESET_BASE = 32; // entry i resets to RESET_BASE + i

    localparam int SAMPLE_W = 8;
    localparam int INDEX_W  = $clog2(DEPTH);
    localparam int PAGE_W   = $clog2(PAGES);

    typedef logic [SAMPLE_W-1:0] sample_t;
    typedef logic [INDEX_W-1:0]  index_t;
    typedef logic [PAGE_W-1:0]   page_t;

    // one-cycle command strobes plus target page
    typedef struct packed {
        logic  save;
        logic  restore;
        page_t page;
    } snap_cmd_t;

    // one entry of the page store
    typedef struct packed {
        page_t  page;
        index_t index;
    } page_addr_t;

endpackage
